// ==== hw/main_pkg.sv ====
// shared address map, region and i/o register types for the main cpu bus glue and its testbench
package main_pkg;

    // word address width, covers byte address bits 18:1
    localparam int addr_w = 18;

    // read value for unmapped space and write-only registers
    localparam logic [15:0] open_bus = 16'hffff;

    // interrupt priority levels, before inversion onto ipl_n
    localparam logic [2:0] irq_vblank = 3'd6;
    localparam logic [2:0] irq_sub    = 3'd5;
    localparam logic [2:0] irq_ext    = 3'd4;

    typedef enum logic [2:0] {
        rom,
        ram,
        disp,   // display ram, locked outside blanking
        io,
        none
    } region_t;

    // i/o register index, byte address bits 4:1
    typedef enum logic [3:0] {
        io_joy    = 4'd0,
        io_sys    = 4'd1,
        io_dip    = 4'd2,
        io_rot1   = 4'd3,
        io_rot2   = 4'd4,
        io_snd    = 4'd8,
        io_prisel = 4'd9,
        io_vclr   = 4'd10,
        io_mcu    = 4'd12
    } io_reg_t;

    // byte address bits 18:16 are the top three word address bits
    function automatic region_t region_of(input logic [addr_w-1:0] a);
        region_t r;
        case (a[addr_w-1 -: 3])
            3'd0, 3'd1, 3'd2, 3'd3: r = rom;
            3'd4:    r = ram;
            3'd5:    r = disp;
            3'd6:    r = io;
            default: r = none;
        endcase
        return r;
    endfunction

    function automatic io_reg_t io_reg_of(input logic [addr_w-1:0] a);
        return io_reg_t'(a[3:0]);
    endfunction

endpackage

// ==== hw/bus_decoder.sv ====
// address decoder for the main cpu bus, gives region selects, i/o read index and one-shot strobes
`timescale 1ns/1ps

module bus_decoder import main_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              as_n,
    input  logic              rnw,
    input  logic [addr_w-1:0] addr,
    output region_t           region,
    output logic              rom_cs,
    output logic              ram_cs,
    output logic              io_rd,
    output io_reg_t           io_rd_sel,
    output logic              wr_pulse_snd,
    output logic              wr_pulse_prisel,
    output logic              wr_pulse_vclr,
    output logic              wr_pulse_mcu,
    output logic              rd_pulse_mcu
);

    logic as_l;      // as_n one cycle back
    logic as_start;  // first cycle of the strobe
    logic io_wr;
    logic readable;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            as_l <= 1'b1;
        end else begin
            as_l <= as_n;
        end
    end

    assign as_start = as_l & ~as_n;

    always_comb begin
        if (as_n) begin
            region = none;
        end else begin
            region = region_of(addr);
        end
    end

    assign rom_cs = region == rom;
    assign ram_cs = (region == ram) || (region == disp);  // one port for both rams

    assign io_rd_sel = io_reg_of(addr);

    always_comb begin
        case (io_rd_sel)
            io_joy, io_sys, io_dip, io_rot1, io_rot2, io_mcu: readable = 1'b1;
            default: readable = 1'b0;
        endcase
    end

    assign io_rd = (region == io) && rnw && readable;

    // strobes fire once per access, however long dtack is held off
    assign io_wr = as_start && (region == io) && !rnw;

    assign wr_pulse_snd    = io_wr && (io_rd_sel == io_snd);
    assign wr_pulse_prisel = io_wr && (io_rd_sel == io_prisel);
    assign wr_pulse_vclr   = io_wr && (io_rd_sel == io_vclr);
    assign wr_pulse_mcu    = io_wr && (io_rd_sel == io_mcu);
    assign rd_pulse_mcu    = as_start && (region == io) && rnw && (io_rd_sel == io_mcu);

    // rom and ram requests never overlap on the shared memory side
    a_one_mem_cs: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, ram_cs}));

endmodule

// ==== hw/irq_encoder.sv ====
// interrupt latches and priority encoder, drives the active-low ipl lines of the main cpu
`timescale 1ns/1ps

module irq_encoder import main_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       lvbl,
    input  logic       sec2,
    input  logic       nexirq,
    input  logic       vclr,
    input  logic       sub_clr,
    output logic [2:0] ipl_n
);

    logic lvbl_l;
    logic sec2_l;
    logic vint;     // vertical blank pending
    logic secirq;   // sub cpu request pending

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l <= 1'b0;  // no false blank edge out of reset
            sec2_l <= 1'b1;
            vint   <= 1'b0;
            secirq <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            sec2_l <= sec2;

            // clear beats a set landing in the same cycle
            if (vclr) begin
                vint <= 1'b0;
            end else if (lvbl_l && !lvbl) begin
                vint <= 1'b1;
            end

            if (sub_clr) begin
                secirq <= 1'b0;
            end else if (!sec2_l && sec2) begin
                secirq <= 1'b1;
            end
        end
    end

    always_comb begin
        if (vint) begin
            ipl_n = ~irq_vblank;
        end else if (secirq) begin
            ipl_n = ~irq_sub;
        end else if (!nexirq) begin
            ipl_n = ~irq_ext;   // level input, not latched
        end else begin
            ipl_n = 3'b111;
        end
    end

endmodule

// ==== hw/dtack_gen.sv ====
// bus acknowledge generator, times dtack_n per region and holds display ram off until blanking
`timescale 1ns/1ps

module dtack_gen import main_pkg::*; #(
    parameter int io_ack_dly = 1
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    as_n,
    input  region_t region,
    input  logic    rom_ok,
    input  logic    ram_ok,
    input  logic    lvbl,
    input  logic    lhbl,
    output logic    dtack_n
);

    localparam int cnt_w = $clog2(io_ack_dly + 2);
    localparam logic [cnt_w-1:0] dly_v = cnt_w'(io_ack_dly);

    logic [cnt_w-1:0] cnt;       // cycles since the strobe was seen, saturating
    logic             first;     // first edge of the access
    logic             mem_ok_l;  // rom or ram ready, one cycle back
    logic             busy;      // display access waiting for blank
    logic [1:0]       disp_sh;
    logic             blank;
    logic             disp_go;
    logic             ack;

    assign first = cnt == '0;
    assign blank = ~lvbl | ~lhbl;

    // blank seen now or on an earlier edge of this access
    assign disp_go = (region == disp) && !as_n && dtack_n && (disp_sh == 2'b00) && ram_ok
                     && (blank || (!busy && !first));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt      <= '0;
            mem_ok_l <= 1'b0;
            busy     <= 1'b0;
            disp_sh  <= 2'b00;
        end else if (as_n) begin
            cnt      <= '0;
            mem_ok_l <= 1'b0;
            busy     <= 1'b0;
            disp_sh  <= 2'b00;
        end else begin
            if (cnt <= dly_v) begin
                cnt <= cnt + 1'b1;
            end
            mem_ok_l <= ((region == rom) && rom_ok) || ((region == ram) && ram_ok);

            if (first && (region == disp)) begin
                busy <= ~blank;
            end else if (blank) begin
                busy <= 1'b0;
            end

            if (disp_go) begin
                disp_sh <= 2'b11;
            end else begin
                disp_sh <= disp_sh >> 1;
            end
        end
    end

    always_comb begin
        case (region)
            rom, ram: ack = mem_ok_l;
            disp:     ack = disp_sh == 2'b01;  // two cycles after the go
            default:  ack = cnt >= dly_v;      // io and unmapped
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dtack_n <= 1'b1;
        end else if (as_n) begin
            dtack_n <= 1'b1;
        end else if (ack) begin
            dtack_n <= 1'b0;   // stays low until the strobe is released
        end
    end

    // a display acknowledge only ever follows a seen blank
    a_disp_blank: assert property (@(posedge clk) disable iff (rst)
        (region == disp && ack) |-> !busy);

endmodule

// ==== hw/cabinet_inputs.sv ====
// cabinet input words for cpu reads: joysticks, system bits, dip switches and two rotary dials
`timescale 1ns/1ps

module cabinet_inputs #(
    parameter int rot_div = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        lvbl,
    input  logic [8:0]  joystick1,
    input  logic [8:0]  joystick2,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    output logic [15:0] joy_word,
    output logic [15:0] sys_word,
    output logic [15:0] dip_word,
    output logic [15:0] rot1_word,
    output logic [15:0] rot2_word
);

    localparam int fc_w = (rot_div > 1) ? $clog2(rot_div) : 1;
    localparam logic [fc_w-1:0] fc_last = fc_w'(rot_div - 1);

    logic [8:0]      sort1;
    logic [8:0]      sort2;
    logic            lvbl_l;
    logic [fc_w-1:0] frame_cnt;
    logic [11:0]     dial1;
    logic [11:0]     dial2;

    // direction bits come in reversed order on the board
    function automatic logic [8:0] sort_joy(input logic [8:0] j);
        return {j[8:4], j[0], j[1], j[2], j[3]};
    endfunction

    // bit 6 turns left, bit 7 right, both pressed cancel out
    function automatic logic [11:0] dial_step(input logic [11:0] dial, input logic [8:0] j);
        logic left;
        logic right;
        logic [11:0] nxt;
        left  = ~j[6];
        right = ~j[7];
        nxt   = dial;
        if (left && !right) begin
            nxt = (dial == 12'h000) ? 12'h001 : {dial[10:0], dial[11]};
        end else if (right && !left) begin
            nxt = (dial == 12'h000) ? 12'h800 : {dial[0], dial[11:1]};
        end
        return nxt;
    endfunction

    assign sort1 = sort_joy(joystick1);
    assign sort2 = sort_joy(joystick2);

    assign joy_word  = {sort2[7:0], sort1[7:0]};
    assign sys_word  = {8'hff, ~lvbl, service, coin_input, start_button, sort2[8], sort1[8]};
    assign dip_word  = {dipsw_b, dipsw_a};
    assign rot1_word = {4'hf, ~dial1};
    assign rot2_word = {4'hf, ~dial2};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l    <= 1'b0;
            frame_cnt <= '0;
            dial1     <= 12'h000;
            dial2     <= 12'h000;
        end else begin
            lvbl_l <= lvbl;
            if (lvbl_l && !lvbl) begin   // start of vertical blank
                frame_cnt <= (frame_cnt == fc_last) ? '0 : frame_cnt + 1'b1;
                if (frame_cnt == '0) begin
                    dial1 <= dial_step(dial1, joystick1);
                    dial2 <= dial_step(dial2, joystick2);
                end
            end
        end
    end

    a_dial_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(dial1) && $onehot0(dial2));

endmodule

// ==== hw/main_bus.sv ====
// main cpu bus glue top level, read data mux and write latches around the decoder and timing blocks
`timescale 1ns/1ps

module main_bus import main_pkg::*; #(
    parameter int rot_div    = 8,
    parameter int io_ack_dly = 1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              as_n,
    input  logic [1:0]        ds_n,      // bit 1 upper byte, bit 0 lower byte
    input  logic              rnw,
    input  logic [addr_w-1:0] addr,
    input  logic [15:0]       cpu_dout,
    output logic [15:0]       cpu_din,
    output logic              dtack_n,
    output logic              rom_cs,
    input  logic [15:0]       rom_data,
    input  logic              rom_ok,
    output logic              ram_cs,
    input  logic [15:0]       ram_data,
    input  logic              ram_ok,
    input  logic              lvbl,
    input  logic              lhbl,
    input  logic              nexirq,
    input  logic              sec2,
    output logic [2:0]        ipl_n,
    output logic              snreq,
    output logic [7:0]        snd_latch,
    input  logic [15:0]       mcu_dout,
    output logic [15:0]       mcu_din,
    output logic              sec_rd,
    output logic [2:0]        prisel,
    input  logic [8:0]        joystick1,
    input  logic [8:0]        joystick2,
    input  logic [1:0]        start_button,
    input  logic [1:0]        coin_input,
    input  logic              service,
    input  logic [7:0]        dipsw_a,
    input  logic [7:0]        dipsw_b
);

    region_t     region;
    io_reg_t     io_rd_sel;
    logic        io_rd;
    logic        wr_pulse_snd;
    logic        wr_pulse_prisel;
    logic        wr_pulse_vclr;
    logic        wr_pulse_mcu;
    logic        rd_pulse_mcu;
    logic [15:0] joy_word;
    logic [15:0] sys_word;
    logic [15:0] dip_word;
    logic [15:0] rot1_word;
    logic [15:0] rot2_word;

    bus_decoder u_decoder (
        .clk             (clk),
        .rst             (rst),
        .as_n            (as_n),
        .rnw             (rnw),
        .addr            (addr),
        .region          (region),
        .rom_cs          (rom_cs),
        .ram_cs          (ram_cs),
        .io_rd           (io_rd),
        .io_rd_sel       (io_rd_sel),
        .wr_pulse_snd    (wr_pulse_snd),
        .wr_pulse_prisel (wr_pulse_prisel),
        .wr_pulse_vclr   (wr_pulse_vclr),
        .wr_pulse_mcu    (wr_pulse_mcu),
        .rd_pulse_mcu    (rd_pulse_mcu)
    );

    irq_encoder u_irq (
        .clk     (clk),
        .rst     (rst),
        .lvbl    (lvbl),
        .sec2    (sec2),
        .nexirq  (nexirq),
        .vclr    (wr_pulse_vclr),
        .sub_clr (rd_pulse_mcu),   // reading the mailbox acks the sub cpu
        .ipl_n   (ipl_n)
    );

    dtack_gen #(.io_ack_dly(io_ack_dly)) u_dtack (
        .clk     (clk),
        .rst     (rst),
        .as_n    (as_n),
        .region  (region),
        .rom_ok  (rom_ok),
        .ram_ok  (ram_ok),
        .lvbl    (lvbl),
        .lhbl    (lhbl),
        .dtack_n (dtack_n)
    );

    cabinet_inputs #(.rot_div(rot_div)) u_cab (
        .clk          (clk),
        .rst          (rst),
        .lvbl         (lvbl),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .joy_word     (joy_word),
        .sys_word     (sys_word),
        .dip_word     (dip_word),
        .rot1_word    (rot1_word),
        .rot2_word    (rot2_word)
    );

    assign snreq  = wr_pulse_snd && !ds_n[0];  // sound latch sits on the low byte
    assign sec_rd = rd_pulse_mcu;

    // sampled every cycle, stable by the time dtack_n drops
    always_ff @(posedge clk) begin
        case (region)
            rom:       cpu_din <= rom_data;
            ram, disp: cpu_din <= ram_data;
            io: begin
                if (!io_rd) begin
                    cpu_din <= open_bus;   // write-only or unused register
                end else begin
                    case (io_rd_sel)
                        io_joy:  cpu_din <= joy_word;
                        io_sys:  cpu_din <= sys_word;
                        io_dip:  cpu_din <= dip_word;
                        io_rot1: cpu_din <= rot1_word;
                        io_rot2: cpu_din <= rot2_word;
                        io_mcu:  cpu_din <= mcu_dout;
                        default: cpu_din <= open_bus;
                    endcase
                end
            end
            default:   cpu_din <= open_bus;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd_latch <= 8'h00;
            mcu_din   <= 16'h0000;
            prisel    <= 3'd0;
        end else begin
            if (snreq) begin
                snd_latch <= cpu_dout[7:0];
            end
            if (wr_pulse_mcu && !ds_n[1]) begin
                mcu_din[15:8] <= cpu_dout[15:8];
            end
            if (wr_pulse_mcu && !ds_n[0]) begin
                mcu_din[7:0] <= cpu_dout[7:0];
            end
            if (wr_pulse_prisel && !ds_n[0]) begin
                prisel <= cpu_dout[2:0];   // colour mixer priority
            end
        end
    end

endmodule

// ==== dv/main_bus_tb.sv ====
// bus-master testbench for the main cpu bus glue, run from sim.f with the Makefile
`timescale 1ns/1ps

module main_bus_tb import main_pkg::*; ();

    localparam int rot_div     = 8;
    localparam int bus_timeout = 200;   // cycles per access

    logic              clk          = 1'b0;
    logic              rst          = 1'b1;
    logic              as_n         = 1'b1;
    logic [1:0]        ds_n         = 2'b11;
    logic              rnw          = 1'b1;
    logic [addr_w-1:0] addr         = '0;
    logic [15:0]       cpu_dout     = '0;
    logic [15:0]       rom_data     = '0;
    logic              rom_ok       = 1'b0;
    logic [15:0]       ram_data     = '0;
    logic              ram_ok       = 1'b0;
    logic              lvbl         = 1'b1;
    logic              lhbl         = 1'b1;
    logic              nexirq       = 1'b1;
    logic              sec2         = 1'b0;
    logic [15:0]       mcu_dout     = '0;
    logic [8:0]        joystick1    = 9'h1ff;
    logic [8:0]        joystick2    = 9'h1ff;
    logic [1:0]        start_button = 2'b11;
    logic [1:0]        coin_input   = 2'b11;
    logic              service      = 1'b1;
    logic [7:0]        dipsw_a      = 8'hff;
    logic [7:0]        dipsw_b      = 8'hff;
    logic [15:0]       cpu_din;
    logic              dtack_n;
    logic              rom_cs;
    logic              ram_cs;
    logic [2:0]        ipl_n;
    logic              snreq;
    logic [7:0]        snd_latch;
    logic [15:0]       mcu_din;
    logic              sec_rd;
    logic [2:0]        prisel;

    integer            seed       = 62;
    int                errors     = 0;
    int                timeouts   = 0;
    int                snreq_cnt  = 0;
    int                sec_rd_cnt = 0;
    int                rom_wait   = -1;
    int                ram_wait   = -1;
    logic [11:0]       dial1_m    = '0;   // expected one-hot dial positions
    logic [11:0]       dial2_m    = '0;
    logic [addr_w-1:0] addr_q[$];
    logic [15:0]       got_q[$];
    logic [15:0]       exp_q[$];

    main_bus #(.rot_div(rot_div), .io_ack_dly(1)) UUT (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    // memory contents as a function of the word address
    function automatic logic [15:0] rom_word(input logic [addr_w-1:0] a);
        return {a[7:0], a[15:8]} ^ {2'b10, a[17:16], 12'h3c5};
    endfunction

    function automatic logic [15:0] ram_word(input logic [addr_w-1:0] a);
        return ~a[15:0] + {14'h0, a[17:16]};
    endfunction

    function automatic logic [8:0] sorted(input logic [8:0] j);
        logic [8:0] s;
        s = j;
        for (int i = 0; i < 4; i++) begin
            s[i] = j[3 - i];   // direction nibble reversed
        end
        return s;
    endfunction

    function automatic logic [11:0] dial_next(input logic [11:0] d, input logic left);
        if (d == 12'h000) begin
            return left ? 12'h001 : 12'h800;
        end
        return left ? {d[10:0], d[11]} : {d[0], d[11:1]};
    endfunction

    function automatic logic [addr_w-1:0] io_addr(input logic [3:0] r);
        return {3'd6, 11'd0, r};
    endfunction

    function automatic logic [15:0] exp_read(input logic [addr_w-1:0] a);
        logic [8:0]  s1;
        logic [8:0]  s2;
        logic [15:0] w;
        s1 = sorted(joystick1);
        s2 = sorted(joystick2);
        w  = open_bus;
        if (a[addr_w-1 -: 3] < 3'd4) begin
            w = rom_word(a);
        end else if (a[addr_w-1 -: 3] < 3'd6) begin
            w = ram_word(a);    // work and display ram share the port
        end else if (a[addr_w-1 -: 3] == 3'd6) begin
            case (a[3:0])
                io_joy:  w = {s2[7:0], s1[7:0]};
                io_sys:  w = {8'hff, ~lvbl, service, coin_input, start_button, s2[8], s1[8]};
                io_dip:  w = {dipsw_b, dipsw_a};
                io_rot1: w = {4'hf, ~dial1_m};
                io_rot2: w = {4'hf, ~dial2_m};
                io_mcu:  w = mcu_dout;
                default: w = open_bus;
            endcase
        end
        return w;
    endfunction

    // rom and ram answer after 0 to 3 cycles
    always @(posedge clk or posedge rst) begin : rom_model
        if (rst || !rom_cs) begin
            rom_ok   <= 1'b0;
            rom_wait = -1;
        end else if (!rom_ok) begin
            if (rom_wait < 0) begin
                rom_wait = rnd() % 4;
            end
            if (rom_wait == 0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_word(addr);
            end else begin
                rom_wait = rom_wait - 1;
            end
        end
    end

    always @(posedge clk or posedge rst) begin : ram_model
        if (rst || !ram_cs) begin
            ram_ok   <= 1'b0;
            ram_wait = -1;
        end else if (!ram_ok) begin
            if (ram_wait < 0) begin
                ram_wait = rnd() % 4;
            end
            if (ram_wait == 0) begin
                ram_ok   <= 1'b1;
                ram_data <= ram_word(addr);
            end else begin
                ram_wait = ram_wait - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (snreq) begin
            snreq_cnt <= snreq_cnt + 1;
        end
        if (sec_rd) begin
            sec_rd_cnt <= sec_rd_cnt + 1;
        end
    end

    always @(negedge clk) begin : compare_reads
        logic [addr_w-1:0] a;
        logic [15:0]       got;
        logic [15:0]       exp;
        while (got_q.size() > 0) begin
            a   = addr_q.pop_front();
            got = got_q.pop_front();
            exp = exp_q.pop_front();
            assert (got == exp) else begin
                errors++;
                $display("mismatch at %0t: read of %h returned %h, expected %h",
                         $time, a, got, exp);
            end
        end
    end

    task automatic bus_access(input logic [addr_w-1:0] a, input logic rd,
                              input logic [15:0] wdata, output logic [15:0] rdata);
        int n;
        n = 0;
        @(posedge clk);
        addr     <= a;
        rnw      <= rd;
        ds_n     <= 2'b00;
        cpu_dout <= wdata;
        as_n     <= 1'b0;
        @(negedge clk);
        while (dtack_n && n < bus_timeout) begin
            n++;
            @(negedge clk);
        end
        rdata = cpu_din;
        if (dtack_n) begin
            timeouts++;
            $display("no acknowledge for address %h after %0d cycles", a, bus_timeout);
        end
        @(posedge clk);
        as_n <= 1'b1;
        ds_n <= 2'b11;
    endtask

    task automatic read_check(input logic [addr_w-1:0] a);
        logic [15:0] got;
        bus_access(a, 1'b1, 16'h0000, got);
        addr_q.push_back(a);
        got_q.push_back(got);
        exp_q.push_back(exp_read(a));
    endtask

    task automatic write_reg(input logic [3:0] r, input logic [15:0] data);
        logic [15:0] unused;
        bus_access(io_addr(r), 1'b0, data, unused);
    endtask

    task automatic scramble_inputs();
        logic [31:0] r;
        logic [31:0] q;
        r = rnd();
        q = rnd();
        @(posedge clk);
        joystick1    <= r[8:0];
        joystick2    <= r[17:9];
        start_button <= r[19:18];
        coin_input   <= r[21:20];
        service      <= r[22];
        dipsw_a      <= q[7:0];
        dipsw_b      <= q[15:8];
        mcu_dout     <= q[31:16];
    endtask

    task automatic vblank_pulse();
        @(posedge clk);
        lvbl <= 1'b0;
        repeat (3) @(posedge clk);
        lvbl <= 1'b1;
        repeat (3) @(posedge clk);
    endtask

    task automatic expect_ipl(input logic [2:0] exp, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (ipl_n != exp && n < 16) begin
            n++;
            @(negedge clk);
        end
        assert (ipl_n == exp) else begin
            errors++;
            $display("mismatch at %0t: ipl_n %b after %s, expected %b", $time, ipl_n, what, exp);
        end
    endtask

    initial begin : run
        logic [31:0]       r;
        logic [addr_w-1:0] a;
        logic [15:0]       got;
        int                n;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        scramble_inputs();

        // random reads, display ram folded onto work ram while video is active
        repeat (40) begin
            r = rnd();
            a = r[addr_w-1:0];
            if (a[addr_w-1 -: 3] == 3'd5) begin
                a[addr_w-3] = 1'b0;
            end
            read_check(a);
        end
        read_check({3'd7, 15'h1234});
        read_check(io_addr(io_snd));
        read_check(io_addr(io_prisel));
        read_check(io_addr(io_vclr));

        // display ram held off until horizontal blank
        r = rnd();
        a = {3'd5, r[14:0]};
        fork
            begin
                bus_access(a, 1'b1, 16'h0000, got);
                assert (!lhbl) else begin
                    errors++;
                    $display("display ram read at %h acknowledged during active video", a);
                end
            end
            begin
                repeat (20) @(posedge clk);
                lhbl <= 1'b0;
            end
        join
        addr_q.push_back(a);
        got_q.push_back(got);
        exp_q.push_back(exp_read(a));
        @(posedge clk);
        lhbl <= 1'b1;

        repeat (3) begin
            r = rnd();
            n = snreq_cnt;
            write_reg(io_snd, r[15:0]);
            assert (snd_latch == r[7:0] && snreq_cnt == n + 1) else begin
                errors++;
                $display("mismatch at %0t: snd_latch %h with %0d snreq pulses, expected %h and 1",
                         $time, snd_latch, snreq_cnt - n, r[7:0]);
            end
            write_reg(io_mcu, r[31:16]);
            assert (mcu_din == r[31:16]) else begin
                errors++;
                $display("mismatch at %0t: mcu_din %h, expected %h", $time, mcu_din, r[31:16]);
            end
            write_reg(io_prisel, {13'd0, r[18:16]});
            assert (prisel == r[18:16]) else begin
                errors++;
                $display("mismatch at %0t: prisel %h, expected %h", $time, prisel, r[18:16]);
            end
        end

        repeat (8) begin
            scramble_inputs();
            read_check(io_addr(io_joy));
            read_check(io_addr(io_sys));
            read_check(io_addr(io_dip));
        end

        // player 1 holds left, player 2 holds right
        @(posedge clk);
        joystick1 <= 9'h1bf;
        joystick2 <= 9'h17f;
        repeat (2) begin
            repeat (2 * rot_div) vblank_pulse();
            dial1_m = dial_next(dial_next(dial1_m, 1'b1), 1'b1);
            dial2_m = dial_next(dial_next(dial2_m, 1'b0), 1'b0);
            read_check(io_addr(io_rot1));
            read_check(io_addr(io_rot2));
        end

        @(posedge clk);
        joystick1 <= 9'h1ff;
        joystick2 <= 9'h1ff;
        write_reg(io_vclr, 16'h0000);
        expect_ipl(3'b111, "vblank clear");
        vblank_pulse();
        expect_ipl(~irq_vblank, "vblank start");
        repeat (10) @(negedge clk);
        assert (ipl_n == ~irq_vblank) else begin
            errors++;
            $display("mismatch at %0t: vblank request dropped before its clear", $time);
        end
        @(posedge clk);
        sec2 <= 1'b1;
        repeat (4) @(posedge clk);   // sub request latched underneath
        expect_ipl(~irq_vblank, "sub request under vblank");
        write_reg(io_vclr, 16'h0000);
        expect_ipl(~irq_sub, "vblank clear with sub pending");
        @(posedge clk);
        sec2 <= 1'b0;
        n = sec_rd_cnt;
        read_check(io_addr(io_mcu));
        assert (sec_rd_cnt == n + 1) else begin
            errors++;
            $display("mismatch at %0t: %0d sec_rd pulses for one mailbox read, expected 1",
                     $time, sec_rd_cnt - n);
        end
        expect_ipl(3'b111, "mailbox read");
        @(posedge clk);
        nexirq <= 1'b0;
        expect_ipl(~irq_ext, "external request");
        @(posedge clk);
        nexirq <= 1'b1;
        expect_ipl(3'b111, "external release");

        n = 0;
        while (got_q.size() > 0 && n < 10) begin
            n++;
            @(negedge clk);
        end
        if (got_q.size() > 0) begin
            errors++;
            $display("%0d read results were never compared", got_q.size());
        end
        $display("checks finished: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
hw/main_pkg.sv
hw/bus_decoder.sv
hw/irq_encoder.sv
hw/dtack_gen.sv
hw/cabinet_inputs.sv
hw/main_bus.sv
dv/main_bus_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = main_bus_tb
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
